//--- common/aluPkg.sv
`default_nettype none

package aluPkg;

	// datapath geometry
	localparam int DataW  = 16;
	localparam int OffW   = 8; // offset or immediate field of a request
	localparam int ShamtW = 4;

	// opcode map of the execute stage
	// the low two bits of the shift opcodes double as the shifter mode
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		RED    = 4'd2,
		XOR    = 4'd3,
		SLL    = 4'd4,
		SRA    = 4'd5,
		ROR    = 4'd6,
		PADDSB = 4'd7,
		LW     = 4'd8,
		SW     = 4'd9,
		LLB    = 4'd10,
		LHB    = 4'd11
	} aluOp_e;

	// architectural condition flags, msb first as negative, overflow, zero
	typedef struct packed {
		logic neg;
		logic ovf;
		logic zero;
	} aluFlags_t;

	// one operation request as it enters the stage
	typedef struct packed {
		aluOp_e           op;
		logic [DataW-1:0] opA;    // base register for memory opcodes
		logic [DataW-1:0] opB;    // store data for SW, shift amount in the low bits
		logic [OffW-1:0]  offset; // word offset or byte immediate
	} execReq_t;

	// one result as it leaves the stage
	typedef struct packed {
		aluOp_e           op;
		logic [DataW-1:0] memAddr;
		logic [DataW-1:0] value;
		aluFlags_t        flags; // flag state after this operation has been applied
	} execRes_t;

endpackage

`default_nettype wire

//--- alu/aluAddSub.sv
`timescale 1ns/1ps
`default_nettype none

module aluAddSub (
	input  wire logic                     sub_i,
	input  wire logic [aluPkg::DataW-1:0] a_i,
	input  wire logic [aluPkg::DataW-1:0] b_i,
	output logic      [aluPkg::DataW-1:0] sum_o,
	output logic                          ovf_o,
	output logic                          neg_o
);

	logic [aluPkg::DataW-1:0] bOp;
	logic [aluPkg::DataW-1:0] rawSum;
	logic                     posOvf;
	logic                     negOvf;

	// subtraction is a plus the complement of b with a carry in
	assign bOp    = sub_i ? ~b_i : b_i;
	assign rawSum = a_i + bOp + {{(aluPkg::DataW-1){1'b0}}, sub_i};

	// two operands of one sign giving a sum of the other sign
	assign posOvf = ~a_i[aluPkg::DataW-1] & ~bOp[aluPkg::DataW-1] & rawSum[aluPkg::DataW-1];
	assign negOvf = a_i[aluPkg::DataW-1] & bOp[aluPkg::DataW-1] & ~rawSum[aluPkg::DataW-1];

	always_comb begin
		if (posOvf) begin
			sum_o = {1'b0, {(aluPkg::DataW-1){1'b1}}}; // clamp to 16'h7FFF
		end else if (negOvf) begin
			sum_o = {1'b1, {(aluPkg::DataW-1){1'b0}}}; // clamp to 16'h8000
		end else begin
			sum_o = rawSum;
		end
	end

	assign ovf_o = posOvf | negOvf;
	assign neg_o = sum_o[aluPkg::DataW-1]; // sign after saturation, not of the raw sum

endmodule

`default_nettype wire

//--- alu/aluShifter.sv
`timescale 1ns/1ps
`default_nettype none

module aluShifter (
	input  wire logic [1:0]                mode_i,
	input  wire logic [aluPkg::DataW-1:0]  val_i,
	input  wire logic [aluPkg::ShamtW-1:0] shamt_i,
	output logic      [aluPkg::DataW-1:0]  out_o
);

	// level i moves the word by 2**i places when bit i of the amount is set
	logic [aluPkg::ShamtW:0][aluPkg::DataW-1:0]   level;
	logic [aluPkg::ShamtW-1:0][aluPkg::DataW-1:0] sllLvl;
	logic [aluPkg::ShamtW-1:0][aluPkg::DataW-1:0] sraLvl;
	logic [aluPkg::ShamtW-1:0][aluPkg::DataW-1:0] rorLvl;

	assign level[0] = val_i;

	for (genvar i = 0; i < aluPkg::ShamtW; i++) begin : g_level
		assign sllLvl[i] = {level[i][aluPkg::DataW-1-(1<<i):0], {(1<<i){1'b0}}};
		assign sraLvl[i] = {{(1<<i){level[i][aluPkg::DataW-1]}}, level[i][aluPkg::DataW-1:(1<<i)]};
		assign rorLvl[i] = {level[i][(1<<i)-1:0], level[i][aluPkg::DataW-1:(1<<i)]};

		always_comb begin
			if (!shamt_i[i]) begin
				level[i+1] = level[i];
			end else begin
				case (mode_i)
					2'd0:    level[i+1] = sllLvl[i];
					2'd1:    level[i+1] = sraLvl[i];
					2'd2:    level[i+1] = rorLvl[i];
					default: level[i+1] = level[i]; // mode 3 passes the word through
				endcase
			end
		end
	end

	assign out_o = level[aluPkg::ShamtW];

endmodule

`default_nettype wire

//--- alu/aluSubword.sv
`timescale 1ns/1ps
`default_nettype none

module aluSubword (
	input  wire logic [aluPkg::DataW-1:0] a_i,
	input  wire logic [aluPkg::DataW-1:0] b_i,
	output logic      [aluPkg::DataW-1:0] redSum_o,
	output logic      [aluPkg::DataW-1:0] paddSum_o
);

	logic [8:0]      byteSumA; // first tree level, one per operand
	logic [8:0]      byteSumB;
	logic [9:0]      redTree;
	logic [3:0][4:0] laneSum;  // one extra bit per lane to see the overflow

	// reduction treats every byte as signed, so each term is sign extended
	assign byteSumA = {a_i[15], a_i[15:8]} + {a_i[7], a_i[7:0]};
	assign byteSumB = {b_i[15], b_i[15:8]} + {b_i[7], b_i[7:0]};

	// second tree level
	assign redTree = {byteSumA[8], byteSumA} + {byteSumB[8], byteSumB};

	assign redSum_o = {{(aluPkg::DataW-10){redTree[9]}}, redTree};

	// four independent nibble lanes, no carry crosses a lane boundary
	for (genvar l = 0; l < 4; l++) begin : g_lane
		assign laneSum[l] = {a_i[4*l+3], a_i[4*l +: 4]} + {b_i[4*l+3], b_i[4*l +: 4]};

		always_comb begin
			case (laneSum[l][4:3])
				2'b01:   paddSum_o[4*l +: 4] = 4'h7; // above 7
				2'b10:   paddSum_o[4*l +: 4] = 4'h8; // below -8
				default: paddSum_o[4*l +: 4] = laneSum[l][3:0];
			endcase
		end
	end

endmodule

`default_nettype wire

//--- alu/aluCompute.sv
`timescale 1ns/1ps
`default_nettype none

module aluCompute (
	input  wire aluPkg::execReq_t          req_i,
	output logic      [aluPkg::DataW-1:0]  memAddr_o,
	output logic      [aluPkg::DataW-1:0]  value_o,
	output aluPkg::aluFlags_t              rawFlags_o
);

	logic [aluPkg::DataW-1:0] addSum;
	logic                     addOvf;
	logic                     addNeg;
	logic [aluPkg::DataW-1:0] shiftOut;
	logic [aluPkg::DataW-1:0] redSum;
	logic [aluPkg::DataW-1:0] paddSum;
	logic [aluPkg::DataW-1:0] xorOut;
	logic [aluPkg::DataW-1:0] preLoad;  // value before the byte load merge
	logic [aluPkg::DataW-1:0] llbVal;
	logic [aluPkg::DataW-1:0] lhbVal;
	logic                     isAddSub;

	aluAddSub u_addSub (
		.sub_i (req_i.op == aluPkg::SUB),
		.a_i   (req_i.opA),
		.b_i   (req_i.opB),
		.sum_o (addSum),
		.ovf_o (addOvf),
		.neg_o (addNeg)
	);

	// opcode low bits select left, arithmetic right or rotate
	aluShifter u_shifter (
		.mode_i  (req_i.op[1:0]),
		.val_i   (req_i.opA),
		.shamt_i (req_i.opB[aluPkg::ShamtW-1:0]),
		.out_o   (shiftOut)
	);

	aluSubword u_subword (
		.a_i       (req_i.opA),
		.b_i       (req_i.opB),
		.redSum_o  (redSum),
		.paddSum_o (paddSum)
	);

	assign xorOut = req_i.opA ^ req_i.opB;

	// even base plus the word offset counted in bytes
	assign memAddr_o = {req_i.opA[aluPkg::DataW-1:1], 1'b0}
		+ {{(aluPkg::DataW-aluPkg::OffW-1){1'b0}}, req_i.offset, 1'b0};

	assign llbVal = {req_i.opA[aluPkg::DataW-1:aluPkg::OffW], req_i.offset};
	assign lhbVal = {req_i.offset, req_i.opA[aluPkg::OffW-1:0]};

	always_comb begin
		case (req_i.op)
			aluPkg::ADD, aluPkg::SUB:               preLoad = addSum;
			aluPkg::RED:                            preLoad = redSum;
			aluPkg::XOR:                            preLoad = xorOut;
			aluPkg::SLL, aluPkg::SRA, aluPkg::ROR:  preLoad = shiftOut;
			aluPkg::PADDSB:                         preLoad = paddSum;
			default:                                preLoad = req_i.opB; // store data for LW and SW
		endcase
	end

	always_comb begin
		case (req_i.op)
			aluPkg::LLB: value_o = llbVal;
			aluPkg::LHB: value_o = lhbVal;
			default:     value_o = preLoad;
		endcase
	end

	assign isAddSub = (req_i.op <= aluPkg::SUB);

	assign rawFlags_o.zero = (preLoad == '0);
	assign rawFlags_o.ovf  = addOvf & isAddSub;
	assign rawFlags_o.neg  = addNeg & isAddSub;

	// the upstream decoder never issues codes 12 to 15
	always_comb begin
		if (!$isunknown(req_i.op)) begin
			opDefined: assert (req_i.op <= aluPkg::LHB)
				else $error("undefined opcode %0d reached the execute stage", req_i.op);
		end
	end

endmodule

`default_nettype wire

//--- logic/pipeStage.sv
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
	parameter type payload_t = logic
) (
	input  wire logic     clk_i,
	input  wire logic     rstN_i,
	input  wire logic     inValid_i,
	output logic          inReady_o,
	input  wire payload_t in_i,
	output logic          outValid_o,
	input  wire logic     outReady_i,
	output payload_t      out_o
);

	logic     validQ;
	payload_t dataQ;

	// the slot can take a new entry when empty or when its entry leaves this cycle
	assign inReady_o = !validQ || outReady_i;

	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			validQ <= 1'b0;
		end else if (inReady_o) begin
			validQ <= inValid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (inValid_i && inReady_o) begin
			dataQ <= in_i; // load only on a transfer so a stalled entry holds
		end
	end

	assign outValid_o = validQ;
	assign out_o      = dataQ;

	// the upstream side must hold a stalled entry until this slot takes it
	stallHold: assert property (@(posedge clk_i) disable iff (!rstN_i)
		inValid_i && !inReady_o |=> inValid_i && $stable(in_i))
		else $error("pipeStage input changed or dropped while stalled");

endmodule

`default_nettype wire

//--- logic/flagReg.sv
`timescale 1ns/1ps
`default_nettype none

module flagReg (
	input  wire logic              clk_i,
	input  wire logic              rstN_i,
	input  wire logic              commit_i,
	input  wire aluPkg::aluOp_e    op_i,
	input  wire aluPkg::aluFlags_t raw_i,
	output aluPkg::aluFlags_t      next_o
);

	aluPkg::aluFlags_t flagsQ;
	aluPkg::aluFlags_t wrMask; // set bits take the raw flag, clear bits keep the old one

	always_comb begin
		case (op_i)
			aluPkg::ADD, aluPkg::SUB:  wrMask = '{neg: 1'b1, ovf: 1'b1, zero: 1'b1};
			aluPkg::XOR, aluPkg::SLL,
			aluPkg::SRA, aluPkg::ROR:  wrMask = '{neg: 1'b0, ovf: 1'b0, zero: 1'b1};
			default:                   wrMask = '{neg: 1'b0, ovf: 1'b0, zero: 1'b0};
		endcase
	end

	assign next_o = (raw_i & wrMask) | (flagsQ & ~wrMask);

	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			flagsQ <= '0;
		end else if (commit_i) begin
			flagsQ <= next_o;
		end
	end

endmodule

`default_nettype wire

//--- logic/execStage.sv
`timescale 1ns/1ps
`default_nettype none

module execStage (
	input  wire logic             clk_i,
	input  wire logic             rstN_i,
	input  wire logic             reqValid_i,
	output logic                  reqReady_o,
	input  wire aluPkg::execReq_t req_i,
	output logic                  resValid_o,
	input  wire logic             resReady_i,
	output aluPkg::execRes_t      res_o
);

	aluPkg::execReq_t         reqQ;
	aluPkg::execRes_t         resD;
	logic                     midValid;
	logic                     midReady;
	logic                     commit;
	logic [aluPkg::DataW-1:0] memAddr;
	logic [aluPkg::DataW-1:0] value;
	aluPkg::aluFlags_t        rawFlags;
	aluPkg::aluFlags_t        nextFlags;

	pipeStage #(.payload_t(aluPkg::execReq_t)) u_reqStage (
		.clk_i      (clk_i),
		.rstN_i     (rstN_i),
		.inValid_i  (reqValid_i),
		.inReady_o  (reqReady_o),
		.in_i       (req_i),
		.outValid_o (midValid),
		.outReady_i (midReady),
		.out_o      (reqQ)
	);

	aluCompute u_compute (
		.req_i      (reqQ),
		.memAddr_o  (memAddr),
		.value_o    (value),
		.rawFlags_o (rawFlags)
	);

	// flags move only when the result slice takes this operation
	assign commit = midValid & midReady;

	flagReg u_flagReg (
		.clk_i    (clk_i),
		.rstN_i   (rstN_i),
		.commit_i (commit),
		.op_i     (reqQ.op),
		.raw_i    (rawFlags),
		.next_o   (nextFlags)
	);

	assign resD = '{op: reqQ.op, memAddr: memAddr, value: value, flags: nextFlags};

	pipeStage #(.payload_t(aluPkg::execRes_t)) u_resStage (
		.clk_i      (clk_i),
		.rstN_i     (rstN_i),
		.inValid_i  (midValid),
		.inReady_o  (midReady),
		.in_i       (resD),
		.outValid_o (resValid_o),
		.outReady_i (resReady_i),
		.out_o      (res_o)
	);

endmodule

`default_nettype wire

//--- tests/execVectors.svh
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// columns: opcode, operand A, operand B, offset, expected address, expected value
// the address column is (A with bit 0 cleared) + 2 * offset for every opcode
typedef struct packed {
	aluPkg::aluOp_e           op;
	logic [aluPkg::DataW-1:0] opA;
	logic [aluPkg::DataW-1:0] opB;
	logic [aluPkg::OffW-1:0]  offset;
	logic [aluPkg::DataW-1:0] expAddr;
	logic [aluPkg::DataW-1:0] expVal;
} execVector_t;

localparam int NumVec = 24;

localparam execVector_t Vectors [NumVec] = '{
	'{aluPkg::LW,     16'h1235, 16'hBEEF, 8'h04, 16'h123C, 16'hBEEF}, // flags still clear
	'{aluPkg::ADD,    16'h0003, 16'h0004, 8'h00, 16'h0002, 16'h0007},
	'{aluPkg::ADD,    16'h7FF0, 16'h0020, 8'h00, 16'h7FF0, 16'h7FFF}, // clamps high
	'{aluPkg::ADD,    16'h8000, 16'hFFFF, 8'h00, 16'h8000, 16'h8000}, // clamps low
	'{aluPkg::SUB,    16'h0005, 16'h0005, 8'h00, 16'h0004, 16'h0000},
	'{aluPkg::SUB,    16'h7FFF, 16'hFFFF, 8'h00, 16'h7FFE, 16'h7FFF},
	'{aluPkg::SUB,    16'h0001, 16'h0003, 8'h00, 16'h0000, 16'hFFFE},
	'{aluPkg::SUB,    16'h8000, 16'h0001, 8'h00, 16'h8000, 16'h8000}, // negative and overflow set
	// byte reduction and nibble lanes
	'{aluPkg::RED,    16'h7F80, 16'h0102, 8'h00, 16'h7F80, 16'h0002},
	'{aluPkg::RED,    16'h8080, 16'h8080, 8'h00, 16'h8080, 16'hFE00},
	'{aluPkg::RED,    16'h7F7F, 16'h7F7F, 8'h00, 16'h7F7E, 16'h01FC},
	'{aluPkg::PADDSB, 16'h7812, 16'h1834, 8'h00, 16'h7812, 16'h7846}, // lanes hit 7 and -8
	'{aluPkg::PADDSB, 16'h0F3C, 16'h0F2D, 8'h00, 16'h0F3C, 16'h0E59},
	// logic and shifts, amount in the low bits of B
	'{aluPkg::XOR,    16'hA5A5, 16'hA5A5, 8'h00, 16'hA5A4, 16'h0000},
	'{aluPkg::SLL,    16'h1234, 16'h0004, 8'h00, 16'h1234, 16'h2340},
	'{aluPkg::SLL,    16'h8001, 16'h000F, 8'h00, 16'h8000, 16'h8000},
	'{aluPkg::SRA,    16'h8000, 16'h000F, 8'h00, 16'h8000, 16'hFFFF},
	'{aluPkg::SRA,    16'h4000, 16'h0000, 8'h00, 16'h4000, 16'h4000},
	'{aluPkg::SRA,    16'h0100, 16'h0009, 8'h00, 16'h0100, 16'h0000},
	'{aluPkg::ROR,    16'h1234, 16'h0008, 8'h00, 16'h1234, 16'h3412},
	'{aluPkg::ROR,    16'h0001, 16'h0001, 8'h00, 16'h0000, 16'h8000},
	// memory and byte loads leave the flags alone
	'{aluPkg::SW,     16'h0100, 16'h0000, 8'hFF, 16'h02FE, 16'h0000},
	'{aluPkg::LLB,    16'hABCD, 16'h0000, 8'h12, 16'hABF0, 16'hAB12},
	'{aluPkg::LHB,    16'hABCD, 16'h1111, 8'h34, 16'hAC34, 16'h34CD}
};

`endif

//--- tests/tb_execStage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_execStage;

	`include "execVectors.svh"

	localparam int TimeoutCycles = 2 * NumVec * 8 + 50; // two passes over the table

	logic              clk;
	logic              rstN;
	logic              reqValid;
	logic              reqReady;
	aluPkg::execReq_t  req;
	logic              resValid;
	logic              resReady;
	aluPkg::execRes_t  res;

	int                cycle;
	int                errCount;
	int                resCount;
	logic              stressOn;  // random back-pressure on the result side
	int unsigned       lcgState;
	aluPkg::aluFlags_t flagModel;
	int                acceptQ[$]; // edge index of every accepted request

	execStage u_dut (
		.clk_i      (clk),
		.rstN_i     (rstN),
		.reqValid_i (reqValid),
		.reqReady_o (reqReady),
		.req_i      (req),
		.resValid_o (resValid),
		.resReady_i (resReady),
		.res_o      (res)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle++;
		if (cycle > TimeoutCycles) begin
			$display("timeout: results stopped arriving after %0d of %0d", resCount, 2 * NumVec);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic int unsigned nextRand(int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// consumer ready, held high until the stress pass begins
	always @(posedge clk) begin
		#2;
		if (stressOn) begin
			lcgState = nextRand(lcgState);
			resReady = lcgState[16];
		end else begin
			resReady = 1'b1;
		end
	end

	// add and sub write all flags, logic and shifts write zero only, the rest keep them
	function automatic aluPkg::aluFlags_t applyFlagRule(aluPkg::aluFlags_t prev, execVector_t v);
		aluPkg::aluFlags_t nxt;
		int sa;
		int sb;
		int wide;
		nxt = prev;
		sa = $signed(v.opA);
		sb = $signed(v.opB);
		wide = (v.op == aluPkg::SUB) ? sa - sb : sa + sb;
		case (v.op)
			aluPkg::ADD, aluPkg::SUB: begin
				nxt.ovf  = (wide > 32767) || (wide < -32768);
				nxt.neg  = v.expVal[aluPkg::DataW-1];
				nxt.zero = (v.expVal == '0);
			end
			aluPkg::XOR, aluPkg::SLL, aluPkg::SRA, aluPkg::ROR: nxt.zero = (v.expVal == '0);
			default: nxt = prev;
		endcase
		return nxt;
	endfunction

	task automatic checkWord(string sigName, logic [aluPkg::DataW-1:0] got,
		logic [aluPkg::DataW-1:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %h expected %h", $time, sigName, got, exp);
			errCount++;
		end
	endtask

	task automatic checkFlags(aluPkg::aluFlags_t got, aluPkg::aluFlags_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t res_o.flags got %b expected %b", $time, got, exp);
			errCount++;
		end
	endtask

	task automatic checkOp(aluPkg::aluOp_e got, aluPkg::aluOp_e exp);
		if (got !== exp) begin
			$display("ERR t=%0t res_o.op got %0d expected %0d", $time, got, exp);
			errCount++;
		end
	endtask

	task automatic checkResult(int idx, int resEdge);
		execVector_t v;
		int errBefore;
		int acceptEdge;
		v = Vectors[idx];
		errBefore = errCount;
		flagModel = applyFlagRule(flagModel, v);
		checkOp(res.op, v.op);
		checkWord("res_o.memAddr", res.memAddr, v.expAddr);
		checkWord("res_o.value", res.value, v.expVal);
		checkFlags(res.flags, flagModel);
		if (resCount == 0) begin
			checkFlags(res.flags, '0); // nothing has written the flags since reset
		end
		if (acceptQ.size() == 0) begin
			$display("result %0d came out with no request outstanding", resCount);
			errCount++;
		end else begin
			acceptEdge = acceptQ.pop_front();
			if (!stressOn && resEdge - acceptEdge != 2) begin
				$display("result %0d took %0d cycles instead of 2", resCount, resEdge - acceptEdge);
				errCount++;
			end
		end
		$display("%s result %0d vector %0d %s addr %h value %h flags %b",
			(errCount == errBefore) ? "ok " : "bad", resCount, idx, v.op.name(),
			res.memAddr, res.value, res.flags);
	endtask

	task automatic driveVectors();
		logic fire;
		for (int pass = 0; pass < 2; pass++) begin
			if (pass == 1) begin
				wait (resCount == NumVec); // first pass drains before the stress starts
				@(negedge clk);
				stressOn = 1'b1;
			end
			@(posedge clk);
			#2;
			for (int i = 0; i < NumVec; i++) begin
				reqValid = 1'b1;
				req = '{op: Vectors[i].op, opA: Vectors[i].opA, opB: Vectors[i].opB,
					offset: Vectors[i].offset};
				do begin
					@(negedge clk);
					fire = reqReady;
				end while (!fire);
				acceptQ.push_back(cycle + 1); // taken on the coming edge
				@(posedge clk);
				#2;
			end
			reqValid = 1'b0;
		end
	endtask

	task automatic collectResults();
		while (resCount < 2 * NumVec) begin
			@(negedge clk);
			if (resValid && resReady) begin
				checkResult(resCount % NumVec, cycle + 1);
				resCount++;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		resReady = 1'b0;
		cycle = 0;
		errCount = 0;
		resCount = 0;
		stressOn = 1'b0;
		lcgState = 95;
		flagModel = '0;
		repeat (2) @(posedge clk);
		#2;
		rstN = 1'b1;
		@(negedge clk);
		if (resValid !== 1'b0 || reqReady !== 1'b1) begin
			$display("handshake outputs wrong after reset, resValid %b reqReady %b", resValid, reqReady);
			errCount++;
		end
		fork
			driveVectors();
			collectResults();
		join
		repeat (4) begin
			@(negedge clk);
			if (resValid) begin
				$display("an extra result came out after the last one");
				errCount++;
			end
		end
		$display("%0d results checked, %0d errors", resCount, errCount);
		if (errCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tests
common/aluPkg.sv
alu/aluAddSub.sv
alu/aluShifter.sv
alu/aluSubword.sv
alu/aluCompute.sv
logic/pipeStage.sv
logic/flagReg.sv
logic/execStage.sv
tests/tb_execStage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_execStage
OBJDIR    ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ** PASS **

SRCS := $(wildcard common/*.sv alu/*.sv logic/*.sv tests/*.sv tests/*.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
